/* hdl/usb_reg_defs.svh */
`ifndef USB_REG_DEFS_SVH
`define USB_REG_DEFS_SVH

// byte counter, wide enough for long FIFO bursts
`define USB_BYTECNT_SIZE 7

// 1: byte count cleared while alen low
// 0: byte count cleared when the latched address changes
`define USB_USE_ALE 1

// register map
`define ADDR_ID       8'h00  // read only, 4 bytes
`define ADDR_SCRATCH  8'h01  // read/write, 4 bytes
`define ADDR_CTRL     8'h02  // bit 0 enables fast fifo read
`define ADDR_STATUS   8'h03  // {overflow, level}
`define ADDR_FIFO     8'h10  // sample fifo head, pops on read

// board identification, lsb read first
`define ID_VALUE 32'hC5A9_0B17

// sample fifo address width, 16 entries
`define FIFO_DEPTH_LOG2 4

`endif

/* hdl/usb_reg_pkg.sv */
`include "usb_reg_defs.svh"

package usb_reg_pkg;

  // one byte on the usb data bus
  typedef logic [7:0] usb_byte_t;

  // register address as latched from the bus
  typedef logic [7:0] usb_addr_t;

  // byte position inside a multi-byte register
  typedef logic [`USB_BYTECNT_SIZE-1:0] reg_bytecnt_t;

  // fifo fill level, one bit wider than the pointers
  typedef logic [`FIFO_DEPTH_LOG2:0] fifo_level_t;

  // register side of the bus front end
  // read is a level, write is a single cycle pulse
  typedef struct packed {
    usb_addr_t    address;  // latched register address
    reg_bytecnt_t bytecnt;  // byte index within the access burst
    usb_byte_t    datao;    // write data, valid with write
    logic         read;     // data due on reg_datai one clock later
    logic         write;    // one clock per host write strobe
  } reg_bus_t;

endpackage

/* hdl/usb_reg_main.sv */
`include "usb_reg_defs.svh"

module usb_reg_main (
  input  logic                    clk_usb,
  input  logic                    reset,
  input  usb_reg_pkg::usb_byte_t  cwusb_din,
  output usb_reg_pkg::usb_byte_t  cwusb_dout,
  output logic                    cwusb_isout,
  input  usb_reg_pkg::usb_addr_t  cwusb_addr,
  input  logic                    cwusb_rdn,
  input  logic                    cwusb_wrn,
  input  logic                    cwusb_cen,
  input  logic                    cwusb_alen,
  input  logic                    fast_fifo_read,
  input  usb_reg_pkg::usb_byte_t  reg_datai,
  output usb_reg_pkg::reg_bus_t   reg_bus
);

  import usb_reg_pkg::*;

  localparam bit use_ale = `USB_USE_ALE;

  logic         isout_r;        // rdn inverted, one register
  logic         isout_dly;      // one more clock, stretches the drive
  logic         wrn_r;          // sampled wrn
  logic         wrn_dly;        // for rising edge detect
  logic         cen_r;
  logic         alen_r;
  logic         write_pulse;
  logic         write_dly;      // bytecnt step after the write
  logic         drive_out;      // bus held for fast fifo reads
  logic         fast_read_r;    // edge detect on fast_fifo_read
  logic         byte_clear;
  logic         read_end;
  usb_addr_t    reg_address;
  usb_byte_t    reg_datao;
  reg_bytecnt_t reg_bytecnt;

  // strobe synchronisers and edge detect
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      isout_r     <= 1'b0;
      isout_dly   <= 1'b0;
      wrn_r       <= 1'b1;  // idle high
      wrn_dly     <= 1'b1;
      cen_r       <= 1'b1;
      alen_r      <= 1'b1;
      write_pulse <= 1'b0;
      write_dly   <= 1'b0;
      fast_read_r <= 1'b0;
    end else begin
      isout_r     <= ~cwusb_rdn;
      isout_dly   <= isout_r;
      wrn_r       <= cwusb_wrn;
      wrn_dly     <= wrn_r;
      cen_r       <= cwusb_cen;
      alen_r      <= cwusb_alen;
      write_pulse <= wrn_r & ~wrn_dly;  // end of host write strobe
      write_dly   <= write_pulse;
      fast_read_r <= fast_fifo_read;
    end
  end

  // latched address and write data
  always_ff @(posedge clk_usb) begin
    reg_address <= cwusb_addr;
    // cen may lead or trail the strobe by a cycle
    if (~wrn_r & (~cwusb_cen | ~cen_r)) begin
      reg_datao <= cwusb_din;
    end
  end

  // bus held from fast fifo read start until the next write
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      drive_out <= 1'b0;
    end else if (~wrn_r) begin
      drive_out <= 1'b0;
    end else if (fast_fifo_read & ~fast_read_r) begin
      drive_out <= 1'b1;
    end
  end

  assign read_end   = isout_dly & ~isout_r;  // one clock after read level drops
  assign byte_clear = use_ale ? ~alen_r : (reg_address != cwusb_addr);

  // byte counter wraps freely
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_bytecnt <= '0;
    end else if (byte_clear) begin
      reg_bytecnt <= '0;
    end else if (read_end | write_dly) begin
      reg_bytecnt <= reg_bytecnt + 1'b1;
    end
  end

  assign cwusb_dout  = reg_datai;  // registered in the bank
  assign cwusb_isout = isout_r | isout_dly | (drive_out & wrn_r);

  assign reg_bus = '{
    address: reg_address,
    bytecnt: reg_bytecnt,
    datao:   reg_datao,
    read:    isout_r,
    write:   write_pulse
  };

  // each host write gives exactly one register write
  a_write_single: assert property (
    @(posedge clk_usb) disable iff (reset) reg_bus.write |=> !reg_bus.write
  ) else $error("reg_bus.write high on two consecutive clocks");

endmodule

/* hdl/reg_bank.sv */
`include "usb_reg_defs.svh"

module reg_bank (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  usb_reg_pkg::reg_bus_t    reg_bus,
  input  usb_reg_pkg::usb_byte_t   fifo_data,
  input  usb_reg_pkg::fifo_level_t fifo_level,
  input  logic                     fifo_overflow,
  output usb_reg_pkg::usb_byte_t   rd_data,
  output logic                     fast_read_en
);

  import usb_reg_pkg::*;

  localparam logic [31:0] id_word = `ID_VALUE;

  usb_byte_t   scratch [4];     // 32 bit scratch, byte addressed
  usb_byte_t   ctrl_reg;
  logic [1:0]  byte_sel;        // bytecnt modulo 4
  logic        wr_scratch;
  logic        wr_ctrl;
  usb_byte_t   status_byte;
  usb_byte_t   rd_next;

  assign byte_sel   = reg_bus.bytecnt[1:0];
  assign wr_scratch = reg_bus.write && (reg_bus.address == `ADDR_SCRATCH);
  assign wr_ctrl    = reg_bus.write && (reg_bus.address == `ADDR_CTRL);

  // scratch is plain storage
  always_ff @(posedge clk_usb) begin
    if (wr_scratch) begin
      scratch[byte_sel] <= reg_bus.datao;
    end
  end

  // control register
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      ctrl_reg <= '0;
    end else if (wr_ctrl) begin
      ctrl_reg <= reg_bus.datao;
    end
  end

  assign fast_read_en = ctrl_reg[0];

  assign status_byte = {fifo_overflow, 7'(fifo_level)};  // level zero extended

  // read mux
  always_comb begin
    case (reg_bus.address)
      `ADDR_ID:      rd_next = id_word[8*byte_sel +: 8];
      `ADDR_SCRATCH: rd_next = scratch[byte_sel];
      `ADDR_CTRL:    rd_next = ctrl_reg;
      `ADDR_STATUS:  rd_next = status_byte;
      `ADDR_FIFO:    rd_next = fifo_data;       // current head
      default:       rd_next = '0;
    endcase
  end

  // registered every clock, valid one clock after read rises
  always_ff @(posedge clk_usb) begin
    rd_data <= rd_next;
  end

  // host never overlaps rdn and wrn, front end delays must keep them apart
  a_no_write_in_read: assert property (
    @(posedge clk_usb) disable iff (reset) (wr_scratch || wr_ctrl) |-> !reg_bus.read
  ) else $error("register write decoded while read is active");

endmodule

/* hdl/sample_fifo.sv */
`include "usb_reg_defs.svh"

module sample_fifo (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  usb_reg_pkg::usb_byte_t   sample_data,
  input  logic                     sample_valid,
  input  usb_reg_pkg::reg_bus_t    reg_bus,
  input  logic                     fast_read_en,
  output usb_reg_pkg::usb_byte_t   fifo_data,
  output usb_reg_pkg::fifo_level_t fifo_level,
  output logic                     fifo_overflow,
  output logic                     fast_fifo_read
);

  import usb_reg_pkg::*;

  localparam int aw    = `FIFO_DEPTH_LOG2;
  localparam int depth = 1 << aw;

  usb_byte_t   mem [depth];   // sample storage
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic        read_r;        // own copy of the read level
  logic        at_fifo;
  logic        full;
  logic        empty;
  logic        push;
  logic        pop;

  assign at_fifo = (reg_bus.address == `ADDR_FIFO);
  assign full    = (fifo_level == fifo_level_t'(depth));
  assign empty   = (fifo_level == '0);
  assign push    = sample_valid & ~full;                   // drop when full
  assign pop     = read_r & ~reg_bus.read & at_fifo & ~empty;  // read just ended

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      read_r <= 1'b0;
    end else begin
      read_r <= reg_bus.read;
    end
  end

  // storage written only on accepted pushes
  always_ff @(posedge clk_usb) begin
    if (push) begin
      mem[wr_ptr] <= sample_data;
    end
  end

  // pointers and level
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_level <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fifo_level <= fifo_level + 1'b1;
        2'b01:   fifo_level <= fifo_level - 1'b1;
        default: fifo_level <= fifo_level;  // none, or both at once
      endcase
    end
  end

  // sticky overflow flag cleared by reset only
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fifo_overflow <= 1'b0;
    end else if (sample_valid & full) begin
      fifo_overflow <= 1'b1;
    end
  end

  assign fifo_data      = mem[rd_ptr];
  assign fast_fifo_read = fast_read_en & at_fifo;  // front end holds the bus

  a_level_bound: assert property (
    @(posedge clk_usb) disable iff (reset) fifo_level <= fifo_level_t'(depth)
  ) else $error("fifo level above depth");

  // read pointer stays put while the fifo is empty
  a_no_pop_empty: assert property (
    @(posedge clk_usb) disable iff (reset)
      empty |=> rd_ptr == $past(rd_ptr)
  ) else $error("fifo pop while empty");

endmodule

/* hdl/usb_reg_top.sv */
module usb_reg_top (
  input  logic                   clk_usb,
  input  logic                   reset,
  input  usb_reg_pkg::usb_byte_t cwusb_din,
  output usb_reg_pkg::usb_byte_t cwusb_dout,
  output logic                   cwusb_isout,
  input  usb_reg_pkg::usb_addr_t cwusb_addr,
  input  logic                   cwusb_rdn,
  input  logic                   cwusb_wrn,
  input  logic                   cwusb_cen,
  input  logic                   cwusb_alen,
  input  usb_reg_pkg::usb_byte_t sample_data,
  input  logic                   sample_valid
);

  import usb_reg_pkg::*;

  reg_bus_t    reg_bus;        // front end to bank and fifo
  usb_byte_t   rd_data;
  logic        fast_read_en;   // ctrl bit 0
  usb_byte_t   fifo_data;
  fifo_level_t fifo_level;
  logic        fifo_overflow;
  logic        fast_fifo_read;

  usb_reg_main i_usb_reg_main (
    .clk_usb        (clk_usb),
    .reset          (reset),
    .cwusb_din      (cwusb_din),
    .cwusb_dout     (cwusb_dout),
    .cwusb_isout    (cwusb_isout),
    .cwusb_addr     (cwusb_addr),
    .cwusb_rdn      (cwusb_rdn),
    .cwusb_wrn      (cwusb_wrn),
    .cwusb_cen      (cwusb_cen),
    .cwusb_alen     (cwusb_alen),
    .fast_fifo_read (fast_fifo_read),
    .reg_datai      (rd_data),
    .reg_bus        (reg_bus)
  );

  reg_bank i_reg_bank (
    .clk_usb       (clk_usb),
    .reset         (reset),
    .reg_bus       (reg_bus),
    .fifo_data     (fifo_data),
    .fifo_level    (fifo_level),
    .fifo_overflow (fifo_overflow),
    .rd_data       (rd_data),
    .fast_read_en  (fast_read_en)
  );

  sample_fifo i_sample_fifo (
    .clk_usb        (clk_usb),
    .reset          (reset),
    .sample_data    (sample_data),
    .sample_valid   (sample_valid),
    .reg_bus        (reg_bus),
    .fast_read_en   (fast_read_en),
    .fifo_data      (fifo_data),
    .fifo_level     (fifo_level),
    .fifo_overflow  (fifo_overflow),
    .fast_fifo_read (fast_fifo_read)
  );

endmodule

/* testbench/usb_reg_tasks.svh */
`ifndef USB_REG_TASKS_SVH
`define USB_REG_TASKS_SVH

task automatic check_byte(input usb_byte_t got, input usb_byte_t exp, input string what);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("FAILED at %0t ns: %s, got 0x%02h expected 0x%02h", $time, what, got, exp);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
  end
endtask

// alen pulse latches the address, byte count back to 0
task automatic set_addr(input usb_addr_t addr);
  @(posedge clk_usb);
  cwusb_addr <= addr;
  cwusb_alen <= 1'b0;
  repeat (2) @(posedge clk_usb);
  cwusb_alen <= 1'b1;
  repeat (2) @(posedge clk_usb);
endtask

task automatic write_byte(input usb_byte_t data);
  @(posedge clk_usb);
  cwusb_din <= data;
  cwusb_wrn <= 1'b0;
  cwusb_cen <= 1'b0;
  repeat (6) @(posedge clk_usb);  // strobe held 6 clocks
  cwusb_wrn <= 1'b1;
  cwusb_cen <= 1'b1;
  repeat (4) @(posedge clk_usb);  // write pulse, register update, bytecnt step
endtask

task automatic read_byte(output usb_byte_t data);
  @(posedge clk_usb);
  cwusb_rdn <= 1'b0;
  cwusb_cen <= 1'b0;
  repeat (5) @(posedge clk_usb);
  @(negedge clk_usb);
  data = cwusb_dout;              // settled well before rdn rises
  @(posedge clk_usb);
  cwusb_rdn <= 1'b1;
  cwusb_cen <= 1'b1;
  repeat (4) @(posedge clk_usb);  // pop and bytecnt step land here
endtask

task automatic bus_write(input usb_addr_t addr, input usb_byte_t data);
  set_addr(addr);
  write_byte(data);
endtask

task automatic bus_read(input usb_addr_t addr, output usb_byte_t data);
  set_addr(addr);
  read_byte(data);
endtask

// one push per clock, full fifo drops the sample
task automatic push_samples(input int n);
  usb_byte_t b;
  for (int i = 0; i < n; i++) begin
    b = usb_byte_t'($random(seed));
    @(posedge clk_usb);
    sample_data  <= b;
    sample_valid <= 1'b1;
    if (exp_q.size() < fifo_depth) begin
      exp_q.push_back(b);
    end else begin
      ovf_model = 1'b1;
    end
  end
  @(posedge clk_usb);
  sample_valid <= 1'b0;
  @(posedge clk_usb);
endtask

function automatic usb_byte_t status_expect();
  return {ovf_model, 7'(exp_q.size())};  // overflow in bit 7, level below
endfunction

task automatic drain_fifo(input int n);
  usb_byte_t got;
  usb_byte_t exp;
  set_addr(`ADDR_FIFO);
  for (int i = 0; i < n; i++) begin
    exp = exp_q.pop_front();
    read_byte(got);
    check_byte(got, exp, $sformatf("fifo sample %0d", i));
  end
endtask

task automatic check_id_burst(input string what);
  logic [31:0] id;
  usb_byte_t   got;
  id = `ID_VALUE;
  set_addr(`ADDR_ID);
  for (int i = 0; i < 4; i++) begin
    read_byte(got);
    check_byte(got, id[8*i +: 8], $sformatf("%s, id byte %0d", what, i));
  end
endtask

task automatic check_scratch_burst(input string what);
  usb_byte_t got;
  set_addr(`ADDR_SCRATCH);
  for (int i = 0; i < 4; i++) begin
    read_byte(got);
    check_byte(got, scratch_model[i], $sformatf("%s, scratch byte %0d", what, i));
  end
endtask

task automatic id_read_burst();
  check_id_burst("id burst");
endtask

task automatic scratch_round_trip();
  set_addr(`ADDR_SCRATCH);
  for (int i = 0; i < 4; i++) begin
    scratch_model[i] = usb_byte_t'($random(seed));
    write_byte(scratch_model[i]);
  end
  check_scratch_burst("full write");
  set_addr(`ADDR_SCRATCH);
  for (int i = 0; i < 2; i++) begin  // bytes 2 and 3 untouched
    scratch_model[i] = usb_byte_t'($random(seed));
    write_byte(scratch_model[i]);
  end
  check_scratch_burst("partial write");
endtask

task automatic bytecnt_restart();
  usb_byte_t got;
  set_addr(`ADDR_SCRATCH);
  read_byte(got);
  check_byte(got, scratch_model[0], "scratch byte 0");
  read_byte(got);
  check_byte(got, scratch_model[1], "scratch byte 1");
  bus_read(`ADDR_SCRATCH, got);  // new alen, back to byte 0
  check_byte(got, scratch_model[0], "scratch byte 0 after alen");
  set_addr(`ADDR_ID);
  write_byte(8'h5a);
  write_byte(8'ha5);
  check_id_burst("id after write");
endtask

task automatic fifo_order_level();
  usb_byte_t got;
  push_samples(5);
  bus_read(`ADDR_STATUS, got);
  check_byte(got, status_expect(), "status after 5 pushes");
  drain_fifo(5);
  bus_read(`ADDR_STATUS, got);
  check_byte(got, status_expect(), "status after drain");
endtask

task automatic overflow_drain();
  usb_byte_t got;
  push_samples(fifo_depth + 3);
  bus_read(`ADDR_STATUS, got);
  check_byte(got, status_expect(), "status after overflow");
  drain_fifo(fifo_depth);
  bus_read(`ADDR_STATUS, got);
  check_byte(got, status_expect(), "status after overflow drain");
endtask

task automatic fast_read_drive();
  usb_byte_t got;
  bus_write(`ADDR_CTRL, 8'h01);
  set_addr(`ADDR_FIFO);
  read_byte(got);
  @(negedge clk_usb);
  check_bit(cwusb_isout, 1'b1, "isout held after fast read");
  @(posedge clk_usb);
  cwusb_din <= 8'h00;
  cwusb_wrn <= 1'b0;
  cwusb_cen <= 1'b0;
  repeat (2) @(posedge clk_usb);
  @(negedge clk_usb);
  check_bit(cwusb_isout, 1'b0, "isout released by write");
  repeat (4) @(posedge clk_usb);
  cwusb_wrn <= 1'b1;
  cwusb_cen <= 1'b1;
  repeat (4) @(posedge clk_usb);
  bus_write(`ADDR_CTRL, 8'h00);
  set_addr(`ADDR_FIFO);
  @(posedge clk_usb);
  cwusb_rdn <= 1'b0;
  cwusb_cen <= 1'b0;
  repeat (6) @(posedge clk_usb);
  cwusb_rdn <= 1'b1;
  cwusb_cen <= 1'b1;
  repeat (2) @(posedge clk_usb);  // plain read drops drive within 3 clocks
  @(negedge clk_usb);
  check_bit(cwusb_isout, 1'b0, "isout after plain read");
  repeat (2) @(posedge clk_usb);
endtask

`endif

/* testbench/tb_usb_reg.sv */
`include "usb_reg_defs.svh"

module tb_usb_reg;
  timeunit 1ns;
  timeprecision 1ps;

  import usb_reg_pkg::*;

  localparam int clk_period     = 20;
  localparam int fifo_depth     = 1 << `FIFO_DEPTH_LOG2;
  localparam int num_bus_cycles = 57;  // host strobes over all tests
  localparam int watchdog_ns    = 2 * num_bus_cycles * 20 * clk_period;

  logic      clk_usb;
  logic      reset;
  usb_byte_t cwusb_din;
  usb_byte_t cwusb_dout;
  logic      cwusb_isout;
  usb_addr_t cwusb_addr;
  logic      cwusb_rdn;
  logic      cwusb_wrn;
  logic      cwusb_cen;
  logic      cwusb_alen;
  usb_byte_t sample_data;
  logic      sample_valid;

  integer    seed = 7;            // $random state
  int        errors = 0;
  int        checks = 0;
  usb_byte_t scratch_model [4];   // expected scratch contents
  usb_byte_t exp_q [$];           // expected fifo contents, head first
  logic      ovf_model = 1'b0;    // expected sticky overflow

  usb_reg_top i_usb_reg_top (
    .clk_usb      (clk_usb),
    .reset        (reset),
    .cwusb_din    (cwusb_din),
    .cwusb_dout   (cwusb_dout),
    .cwusb_isout  (cwusb_isout),
    .cwusb_addr   (cwusb_addr),
    .cwusb_rdn    (cwusb_rdn),
    .cwusb_wrn    (cwusb_wrn),
    .cwusb_cen    (cwusb_cen),
    .cwusb_alen   (cwusb_alen),
    .sample_data  (sample_data),
    .sample_valid (sample_valid)
  );

  `include "usb_reg_tasks.svh"

  initial begin
    clk_usb = 1'b0;
    forever #(clk_period / 2) clk_usb = ~clk_usb;
  end

  initial begin
    reset        = 1'b1;
    cwusb_din    = '0;
    cwusb_addr   = '0;
    cwusb_rdn    = 1'b1;  // strobes idle high
    cwusb_wrn    = 1'b1;
    cwusb_cen    = 1'b1;
    cwusb_alen   = 1'b1;
    sample_data  = '0;
    sample_valid = 1'b0;
    repeat (16) @(posedge clk_usb);
    reset <= 1'b0;
    repeat (4) @(posedge clk_usb);
    id_read_burst();
    scratch_round_trip();
    bytecnt_restart();
    fifo_order_level();
    overflow_drain();
    fast_read_drive();
    repeat (4) @(posedge clk_usb);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // stuck handshake or strobe ends the run
  initial begin
    #(watchdog_ns);
    $display("ERROR: timeout after %0d ns, test sequence did not finish", watchdog_ns);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+hdl
+incdir+testbench
hdl/usb_reg_pkg.sv
hdl/usb_reg_main.sv
hdl/reg_bank.sv
hdl/sample_fifo.sv
hdl/usb_reg_top.sv
testbench/tb_usb_reg.sv
